/* Bender.yml */
package:
  name: csr_top

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/csr_pkg.sv
      - design/csr_decode.sv
      - design/csr_exc_regs.sv
      - design/csr_timer.sv
      - design/csr_read_irq.sv
      - design/csr_top.sv
  - target: test
    include_dirs:
      - common
    files:
      - tb/tb_csr_top.sv

/* common/csr_params.svh */
`ifndef CSR_PARAMS_SVH
`define CSR_PARAMS_SVH

// datapath widths
`define CSR_DATA_W      32
`define CSR_NUM_W       14
`define CSR_ECODE_W     6
`define CSR_ESUB_W      9
`define CSR_HWI_W       8
`define CSR_IS_W        13
`define CSR_STABLE_W    64
`define CSR_EENTRY_LSB  6

// count value meaning the timer is stopped
`define CSR_TIMER_IDLE  32'hffff_ffff

// csr addresses
`define CSR_NUM_CRMD    14'h000
`define CSR_NUM_PRMD    14'h001
`define CSR_NUM_ECFG    14'h004
`define CSR_NUM_ESTAT   14'h005
`define CSR_NUM_ERA     14'h006
`define CSR_NUM_BADV    14'h007
`define CSR_NUM_EENTRY  14'h00c
`define CSR_NUM_SAVE0   14'h030
`define CSR_NUM_SAVE1   14'h031
`define CSR_NUM_SAVE2   14'h032
`define CSR_NUM_SAVE3   14'h033
`define CSR_NUM_TCFG    14'h041
`define CSR_NUM_TVAL    14'h042
`define CSR_NUM_TICLR   14'h044

// exception codes that load badv
`define CSR_ECODE_ADE   6'h08
`define CSR_ECODE_ALE   6'h09

`endif

/* common/csr_pkg.sv */
`include "csr_params.svh"

package csr_pkg;

    // implemented csrs, CSR_NONE for anything unmapped
    typedef enum logic [3:0] {
        CSR_NONE,
        CSR_CRMD,
        CSR_PRMD,
        CSR_ECFG,
        CSR_ESTAT,
        CSR_ERA,
        CSR_BADV,
        CSR_EENTRY,
        CSR_SAVE0,
        CSR_SAVE1,
        CSR_SAVE2,
        CSR_SAVE3,
        CSR_TCFG,
        CSR_TVAL,
        CSR_TICLR
    } csr_id_e;

    // where badv is loaded from on exception entry
    typedef enum logic [1:0] {
        BADV_KEEP,
        BADV_PC,
        BADV_VADDR
    } badv_src_e;

    typedef struct packed {
        logic                   we;
        logic [`CSR_DATA_W-1:0] mask;
        logic [`CSR_DATA_W-1:0] value;
    } csr_write_t;

    typedef struct packed {
        logic                    ex;
        logic                    ertn;
        logic [`CSR_ECODE_W-1:0] ecode;
        logic [`CSR_ESUB_W-1:0]  esubcode;
        logic [`CSR_DATA_W-1:0]  pc;
        logic [`CSR_DATA_W-1:0]  vaddr;
    } exc_event_t;

    typedef struct packed {
        logic [1:0]                                crmd_plv;
        logic                                      crmd_ie;
        logic                                      crmd_da;
        logic [1:0]                                prmd_pplv;
        logic                                      prmd_pie;
        logic [`CSR_IS_W-1:0]                      ecfg_lie;
        logic [1:0]                                swi;
        logic [`CSR_HWI_W-1:0]                     hwi;
        logic                                      ipi;
        logic [`CSR_ECODE_W-1:0]                   ecode;
        logic [`CSR_ESUB_W-1:0]                    esubcode;
        logic [`CSR_DATA_W-1:0]                    era;
        logic [`CSR_DATA_W-1:0]                    badv;
        logic [`CSR_DATA_W-1:`CSR_EENTRY_LSB]      eentry;
        logic [3:0][`CSR_DATA_W-1:0]               save;
    } exc_state_t;

    typedef struct packed {
        logic                   tcfg_en;
        logic                   tcfg_periodic;
        logic [`CSR_DATA_W-3:0] tcfg_initval;
        logic [`CSR_DATA_W-1:0] count;
        logic                   ti;
    } timer_state_t;

endpackage

/* design/csr_decode.sv */
`include "csr_params.svh"

module csr_decode (
    input  logic [`CSR_NUM_W-1:0] csr_num,
    input  csr_pkg::exc_event_t   exc,
    output csr_pkg::csr_id_e      csr_id,
    output csr_pkg::badv_src_e    badv_src
);

    // address to identifier, everything downstream works on csr_id
    always_comb begin
        case (csr_num)
            `CSR_NUM_CRMD:   csr_id = csr_pkg::CSR_CRMD;
            `CSR_NUM_PRMD:   csr_id = csr_pkg::CSR_PRMD;
            `CSR_NUM_ECFG:   csr_id = csr_pkg::CSR_ECFG;
            `CSR_NUM_ESTAT:  csr_id = csr_pkg::CSR_ESTAT;
            `CSR_NUM_ERA:    csr_id = csr_pkg::CSR_ERA;
            `CSR_NUM_BADV:   csr_id = csr_pkg::CSR_BADV;
            `CSR_NUM_EENTRY: csr_id = csr_pkg::CSR_EENTRY;
            `CSR_NUM_SAVE0:  csr_id = csr_pkg::CSR_SAVE0;
            `CSR_NUM_SAVE1:  csr_id = csr_pkg::CSR_SAVE1;
            `CSR_NUM_SAVE2:  csr_id = csr_pkg::CSR_SAVE2;
            `CSR_NUM_SAVE3:  csr_id = csr_pkg::CSR_SAVE3;
            `CSR_NUM_TCFG:   csr_id = csr_pkg::CSR_TCFG;
            `CSR_NUM_TVAL:   csr_id = csr_pkg::CSR_TVAL;
            `CSR_NUM_TICLR:  csr_id = csr_pkg::CSR_TICLR;
            default:         csr_id = csr_pkg::CSR_NONE;
        endcase
    end

    // fetch address error reports the pc, misaligned access the data address
    always_comb begin
        if (exc.ecode == `CSR_ECODE_ADE && exc.esubcode == '0) begin
            badv_src = csr_pkg::BADV_PC;
        end else if (exc.ecode == `CSR_ECODE_ALE) begin
            badv_src = csr_pkg::BADV_VADDR;
        end else begin
            badv_src = csr_pkg::BADV_KEEP;
        end
    end

endmodule

/* design/csr_exc_regs.sv */
`include "csr_params.svh"

module csr_exc_regs (
    input  logic                  clk,
    input  logic                  reset,
    input  csr_pkg::csr_id_e      csr_id,
    input  csr_pkg::csr_write_t   wr,
    input  csr_pkg::exc_event_t   exc,
    input  csr_pkg::badv_src_e    badv_src,
    input  logic [`CSR_HWI_W-1:0] hw_int_in,
    input  logic                  ipi_int_in,
    output csr_pkg::exc_state_t   state
);

    logic [1:0]                           crmd_plv;
    logic                                 crmd_ie;
    logic                                 crmd_da;
    logic [1:0]                           prmd_pplv;
    logic                                 prmd_pie;
    logic [`CSR_IS_W-1:0]                 ecfg_lie;
    logic [`CSR_IS_W-1:0]                 ecfg_wval;
    logic [1:0]                           swi;
    logic [`CSR_HWI_W-1:0]                hwi;
    logic                                 ipi;
    logic [`CSR_ECODE_W-1:0]              ecode;
    logic [`CSR_ESUB_W-1:0]               esubcode;
    logic [`CSR_DATA_W-1:0]               era;
    logic [`CSR_DATA_W-1:0]               badv;
    logic [`CSR_DATA_W-1:`CSR_EENTRY_LSB] eentry;
    logic [3:0][`CSR_DATA_W-1:0]          save;
    logic [3:0]                           save_we;

    always_comb begin
        save_we = '0;
        case (csr_id)
            csr_pkg::CSR_SAVE0: save_we[0] = wr.we;
            csr_pkg::CSR_SAVE1: save_we[1] = wr.we;
            csr_pkg::CSR_SAVE2: save_we[2] = wr.we;
            csr_pkg::CSR_SAVE3: save_we[3] = wr.we;
            default:            save_we = '0;
        endcase
    end

    assign ecfg_wval = wr.mask[`CSR_IS_W-1:0] & wr.value[`CSR_IS_W-1:0]
                     | ~wr.mask[`CSR_IS_W-1:0] & ecfg_lie;

    // crmd: entry, then return, then write
    always_ff @(posedge clk) begin
        if (reset) begin
            crmd_plv <= 2'b0;
            crmd_ie  <= 1'b0;
            crmd_da  <= 1'b1;
        end else if (exc.ex) begin
            crmd_plv <= 2'b0;
            crmd_ie  <= 1'b0;
            crmd_da  <= 1'b1;
        end else if (exc.ertn) begin
            crmd_plv <= prmd_pplv;
            crmd_ie  <= prmd_pie;
        end else if (wr.we && csr_id == csr_pkg::CSR_CRMD) begin
            crmd_plv <= wr.mask[1:0] & wr.value[1:0] | ~wr.mask[1:0] & crmd_plv;
            crmd_ie  <= wr.mask[2] & wr.value[2] | ~wr.mask[2] & crmd_ie;
            crmd_da  <= wr.mask[3] & wr.value[3] | ~wr.mask[3] & crmd_da;
        end
    end

    // prmd, era and badv: entry wins over a write
    always_ff @(posedge clk) begin
        if (reset) begin
            prmd_pplv <= 2'b0;
            prmd_pie  <= 1'b0;
            era       <= '0;
            badv      <= '0;
        end else begin
            if (exc.ex) begin
                prmd_pplv <= crmd_plv;
                prmd_pie  <= crmd_ie;
            end else if (wr.we && csr_id == csr_pkg::CSR_PRMD) begin
                prmd_pplv <= wr.mask[1:0] & wr.value[1:0] | ~wr.mask[1:0] & prmd_pplv;
                prmd_pie  <= wr.mask[2] & wr.value[2] | ~wr.mask[2] & prmd_pie;
            end
            if (exc.ex) begin
                era <= exc.pc;
            end else if (wr.we && csr_id == csr_pkg::CSR_ERA) begin
                era <= wr.mask & wr.value | ~wr.mask & era;
            end
            // other exception codes leave badv alone
            if (exc.ex && badv_src != csr_pkg::BADV_KEEP) begin
                badv <= (badv_src == csr_pkg::BADV_PC) ? exc.pc : exc.vaddr;
            end else if (wr.we && csr_id == csr_pkg::CSR_BADV) begin
                badv <= wr.mask & wr.value | ~wr.mask & badv;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (exc.ex) begin
            ecode    <= exc.ecode;
            esubcode <= exc.esubcode;
        end
    end

    // config, scratch and interrupt sampling
    always_ff @(posedge clk) begin
        if (reset) begin
            ecfg_lie <= '0;
            swi      <= 2'b0;
            hwi      <= '0;
            ipi      <= 1'b0;
            eentry   <= '0;
            save     <= '0;
        end else begin
            if (wr.we && csr_id == csr_pkg::CSR_ECFG) begin
                ecfg_lie <= {ecfg_wval[12:11], 1'b0, ecfg_wval[9:0]};
            end
            if (wr.we && csr_id == csr_pkg::CSR_ESTAT) begin
                swi <= wr.mask[1:0] & wr.value[1:0] | ~wr.mask[1:0] & swi;
            end
            if (wr.we && csr_id == csr_pkg::CSR_EENTRY) begin
                eentry <= wr.mask[`CSR_DATA_W-1:`CSR_EENTRY_LSB]
                        & wr.value[`CSR_DATA_W-1:`CSR_EENTRY_LSB]
                        | ~wr.mask[`CSR_DATA_W-1:`CSR_EENTRY_LSB] & eentry;
            end
            for (int i = 0; i < 4; i++) begin
                if (save_we[i]) begin
                    save[i] <= wr.mask & wr.value | ~wr.mask & save[i];
                end
            end
            hwi <= hw_int_in;
            ipi <= ipi_int_in;
        end
    end

    always_comb begin
        state.crmd_plv  = crmd_plv;
        state.crmd_ie   = crmd_ie;
        state.crmd_da   = crmd_da;
        state.prmd_pplv = prmd_pplv;
        state.prmd_pie  = prmd_pie;
        state.ecfg_lie  = ecfg_lie;
        state.swi       = swi;
        state.hwi       = hwi;
        state.ipi       = ipi;
        state.ecode     = ecode;
        state.esubcode  = esubcode;
        state.era       = era;
        state.badv      = badv;
        state.eentry    = eentry;
        state.save      = save;
    end

endmodule

/* design/csr_read_irq.sv */
`include "csr_params.svh"

module csr_read_irq (
    input  logic                   csr_re,
    input  csr_pkg::csr_id_e       csr_id,
    input  csr_pkg::exc_state_t    state,
    input  csr_pkg::timer_state_t  tstate,
    output logic [`CSR_DATA_W-1:0] csr_rvalue,
    output logic [`CSR_DATA_W-1:0] csr_eentry,
    output logic                   has_int
);

    logic [`CSR_IS_W-1:0]   int_status;
    logic [`CSR_DATA_W-1:0] crmd;
    logic [`CSR_DATA_W-1:0] prmd;
    logic [`CSR_DATA_W-1:0] ecfg;
    logic [`CSR_DATA_W-1:0] estat;
    logic [`CSR_DATA_W-1:0] tcfg;
    logic [`CSR_DATA_W-1:0] rdata;

    // ipi, timer, reserved bit 10, hardware lines, software bits
    assign int_status = {state.ipi, tstate.ti, 1'b0, state.hwi, state.swi};

    assign crmd  = {28'b0, state.crmd_da, state.crmd_ie, state.crmd_plv};
    assign prmd  = {29'b0, state.prmd_pie, state.prmd_pplv};
    assign ecfg  = {{(`CSR_DATA_W - `CSR_IS_W){1'b0}}, state.ecfg_lie};
    assign estat = {1'b0, state.esubcode, state.ecode, 3'b0, int_status};
    assign tcfg  = {tstate.tcfg_initval, tstate.tcfg_periodic, tstate.tcfg_en};

    assign csr_eentry = {state.eentry, {`CSR_EENTRY_LSB{1'b0}}};

    always_comb begin
        case (csr_id)
            csr_pkg::CSR_CRMD:   rdata = crmd;
            csr_pkg::CSR_PRMD:   rdata = prmd;
            csr_pkg::CSR_ECFG:   rdata = ecfg;
            csr_pkg::CSR_ESTAT:  rdata = estat;
            csr_pkg::CSR_ERA:    rdata = state.era;
            csr_pkg::CSR_BADV:   rdata = state.badv;
            csr_pkg::CSR_EENTRY: rdata = csr_eentry;
            csr_pkg::CSR_SAVE0:  rdata = state.save[0];
            csr_pkg::CSR_SAVE1:  rdata = state.save[1];
            csr_pkg::CSR_SAVE2:  rdata = state.save[2];
            csr_pkg::CSR_SAVE3:  rdata = state.save[3];
            csr_pkg::CSR_TCFG:   rdata = tcfg;
            csr_pkg::CSR_TVAL:   rdata = tstate.count;
            // ticlr is write-only and reads as zero
            default:             rdata = '0;
        endcase
    end

    assign csr_rvalue = csr_re ? rdata : '0;

    // bit 12 (ipi) is not a maskable source here
    assign has_int = (|(int_status[11:0] & state.ecfg_lie[11:0])) && state.crmd_ie;

endmodule

/* design/csr_timer.sv */
`include "csr_params.svh"

module csr_timer (
    input  logic                     clk,
    input  logic                     reset,
    input  csr_pkg::csr_id_e         csr_id,
    input  csr_pkg::csr_write_t      wr,
    output csr_pkg::timer_state_t    tstate,
    output logic [`CSR_STABLE_W-1:0] stable_counter_value
);

    logic                     tcfg_en;
    logic                     tcfg_periodic;
    logic [`CSR_DATA_W-3:0]   tcfg_initval;
    logic [`CSR_DATA_W-1:0]   tcfg_cur;
    logic [`CSR_DATA_W-1:0]   tcfg_next;
    logic [`CSR_DATA_W-1:0]   count;
    logic                     ti;
    logic                     wr_tcfg;
    logic                     ti_clr;
    logic [`CSR_STABLE_W-1:0] stable_cnt;

    assign wr_tcfg = wr.we && csr_id == csr_pkg::CSR_TCFG;
    assign ti_clr  = wr.we && csr_id == csr_pkg::CSR_TICLR && wr.mask[0] && wr.value[0];

    // tcfg as it will look after this write, decides the start
    assign tcfg_cur  = {tcfg_initval, tcfg_periodic, tcfg_en};
    assign tcfg_next = wr.mask & wr.value | ~wr.mask & tcfg_cur;

    always_ff @(posedge clk) begin
        if (reset) begin
            tcfg_en       <= 1'b0;
            tcfg_periodic <= 1'b0;
            tcfg_initval  <= '0;
        end else if (wr_tcfg) begin
            {tcfg_initval, tcfg_periodic, tcfg_en} <= tcfg_next;
        end
    end

    // one-shot mode wraps from zero to idle and stays there
    always_ff @(posedge clk) begin
        if (reset) begin
            count <= `CSR_TIMER_IDLE;
        end else if (wr_tcfg && tcfg_next[0]) begin
            count <= {tcfg_next[`CSR_DATA_W-1:2], 2'b0};
        end else if (tcfg_en && count != `CSR_TIMER_IDLE) begin
            if (count == '0 && tcfg_periodic) begin
                count <= {tcfg_initval, 2'b0};
            end else begin
                count <= count - 1'b1;
            end
        end
    end

    // set at zero beats a ticlr clear
    always_ff @(posedge clk) begin
        if (reset) begin
            ti <= 1'b0;
        end else if (count == '0) begin
            ti <= 1'b1;
        end else if (ti_clr) begin
            ti <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            stable_cnt <= '0;
        end else begin
            stable_cnt <= stable_cnt + 1'b1;
        end
    end

    assign stable_counter_value = stable_cnt;

    always_comb begin
        tstate.tcfg_en       = tcfg_en;
        tstate.tcfg_periodic = tcfg_periodic;
        tstate.tcfg_initval  = tcfg_initval;
        tstate.count         = count;
        tstate.ti            = ti;
    end

endmodule

/* design/csr_top.sv */
`include "csr_params.svh"

module csr_top (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     csr_re,
    input  logic [`CSR_NUM_W-1:0]    csr_num,
    input  logic                     csr_we,
    input  logic [`CSR_DATA_W-1:0]   csr_wmask,
    input  logic [`CSR_DATA_W-1:0]   csr_wvalue,
    input  logic                     wb_ex,
    input  logic                     ertn_flush,
    input  logic [`CSR_ECODE_W-1:0]  wb_ecode,
    input  logic [`CSR_ESUB_W-1:0]   wb_esubcode,
    input  logic [`CSR_DATA_W-1:0]   wb_pc,
    input  logic [`CSR_DATA_W-1:0]   wb_vaddr,
    input  logic [`CSR_HWI_W-1:0]    hw_int_in,
    input  logic                     ipi_int_in,
    output logic [`CSR_DATA_W-1:0]   csr_rvalue,
    output logic [`CSR_DATA_W-1:0]   csr_eentry,
    output logic                     has_int,
    output logic [`CSR_STABLE_W-1:0] stable_counter_value
);

    csr_pkg::csr_write_t   wr;
    csr_pkg::exc_event_t   exc;
    csr_pkg::csr_id_e      csr_id;
    csr_pkg::badv_src_e    badv_src;
    csr_pkg::exc_state_t   state;
    csr_pkg::timer_state_t tstate;

    assign wr  = '{we: csr_we, mask: csr_wmask, value: csr_wvalue};
    assign exc = '{ex: wb_ex, ertn: ertn_flush, ecode: wb_ecode,
                   esubcode: wb_esubcode, pc: wb_pc, vaddr: wb_vaddr};

    csr_decode decode_i (
        .csr_num  (csr_num),
        .exc      (exc),
        .csr_id   (csr_id),
        .badv_src (badv_src)
    );

    csr_exc_regs exc_regs_i (
        .clk        (clk),
        .reset      (reset),
        .csr_id     (csr_id),
        .wr         (wr),
        .exc        (exc),
        .badv_src   (badv_src),
        .hw_int_in  (hw_int_in),
        .ipi_int_in (ipi_int_in),
        .state      (state)
    );

    csr_timer timer_i (
        .clk                  (clk),
        .reset                (reset),
        .csr_id               (csr_id),
        .wr                   (wr),
        .tstate               (tstate),
        .stable_counter_value (stable_counter_value)
    );

    csr_read_irq read_irq_i (
        .csr_re     (csr_re),
        .csr_id     (csr_id),
        .state      (state),
        .tstate     (tstate),
        .csr_rvalue (csr_rvalue),
        .csr_eentry (csr_eentry),
        .has_int    (has_int)
    );

endmodule

/* flist.f */
+incdir+common
common/csr_pkg.sv
design/csr_decode.sv
design/csr_exc_regs.sv
design/csr_timer.sv
design/csr_read_irq.sv
design/csr_top.sv
tb/tb_csr_top.sv

/* tb/tb_csr_top.sv */
`include "csr_params.svh"

module tb_csr_top;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int timeout_cycles = 2000;

    logic                     clk;
    logic                     reset;
    logic                     csr_re;
    logic [`CSR_NUM_W-1:0]    csr_num;
    logic                     csr_we;
    logic [`CSR_DATA_W-1:0]   csr_wmask;
    logic [`CSR_DATA_W-1:0]   csr_wvalue;
    logic                     wb_ex;
    logic                     ertn_flush;
    logic [`CSR_ECODE_W-1:0]  wb_ecode;
    logic [`CSR_ESUB_W-1:0]   wb_esubcode;
    logic [`CSR_DATA_W-1:0]   wb_pc;
    logic [`CSR_DATA_W-1:0]   wb_vaddr;
    logic [`CSR_HWI_W-1:0]    hw_int_in;
    logic                     ipi_int_in;
    logic [`CSR_DATA_W-1:0]   csr_rvalue;
    logic [`CSR_DATA_W-1:0]   csr_eentry;
    logic                     has_int;
    logic [`CSR_STABLE_W-1:0] stable_counter_value;

    // reference model
    logic [3:0]  m_crmd;
    logic [2:0]  m_prmd;
    logic [12:0] m_ecfg;
    logic [1:0]  m_swi;
    logic [7:0]  m_hwi;
    logic        m_ipi;
    logic [5:0]  m_ecode;
    logic [8:0]  m_esub;
    logic [31:0] m_era;
    logic [31:0] m_badv;
    logic [31:0] m_eentry;
    logic [31:0] m_save [4];
    logic [31:0] m_tcfg;
    logic [31:0] m_count;
    logic        m_ti;
    logic [63:0] m_stable;
    logic [12:0] m_is;
    logic [31:0] tcfg_after;
    logic [31:0] exp_rvalue;
    logic        exp_has_int;

    int    errors = 0;
    int    cycles = 0;
    string test_name = "reset";

    csr_top dut_i (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic logic [31:0] masked(input logic [31:0] old);
        return csr_wmask & csr_wvalue | ~csr_wmask & old;
    endfunction

    assign tcfg_after = csr_wmask & csr_wvalue | ~csr_wmask & m_tcfg;

    // later assignments win, so entry and return override a write
    always @(posedge clk) begin
        if (reset) begin
            m_crmd   <= 4'b1000;
            m_prmd   <= '0;
            m_ecfg   <= '0;
            m_swi    <= '0;
            m_hwi    <= '0;
            m_ipi    <= 1'b0;
            m_ecode  <= '0;
            m_esub   <= '0;
            m_era    <= '0;
            m_badv   <= '0;
            m_eentry <= '0;
            m_save   <= '{default: '0};
            m_tcfg   <= '0;
            m_count  <= `CSR_TIMER_IDLE;
            m_ti     <= 1'b0;
            m_stable <= '0;
        end else begin
            m_stable <= m_stable + 1;
            m_hwi    <= hw_int_in;
            m_ipi    <= ipi_int_in;
            if (csr_we) begin
                case (csr_num)
                    `CSR_NUM_CRMD:   m_crmd <= 4'(masked({28'b0, m_crmd}));
                    `CSR_NUM_PRMD:   m_prmd <= 3'(masked({29'b0, m_prmd}));
                    `CSR_NUM_ECFG:   m_ecfg <= 13'(masked({19'b0, m_ecfg})) & 13'h1bff;
                    `CSR_NUM_ESTAT:  m_swi <= 2'(masked({30'b0, m_swi}));
                    `CSR_NUM_ERA:    m_era <= masked(m_era);
                    `CSR_NUM_BADV:   m_badv <= masked(m_badv);
                    `CSR_NUM_EENTRY: m_eentry <= masked(m_eentry) & 32'hffff_ffc0;
                    `CSR_NUM_SAVE0:  m_save[0] <= masked(m_save[0]);
                    `CSR_NUM_SAVE1:  m_save[1] <= masked(m_save[1]);
                    `CSR_NUM_SAVE2:  m_save[2] <= masked(m_save[2]);
                    `CSR_NUM_SAVE3:  m_save[3] <= masked(m_save[3]);
                    `CSR_NUM_TCFG:   m_tcfg <= tcfg_after;
                    default:         ;
                endcase
            end
            if (wb_ex) begin
                m_crmd  <= 4'b1000;
                m_prmd  <= m_crmd[2:0];
                m_era   <= wb_pc;
                m_ecode <= wb_ecode;
                m_esub  <= wb_esubcode;
                if (wb_ecode == `CSR_ECODE_ADE && wb_esubcode == '0) begin
                    m_badv <= wb_pc;
                end else if (wb_ecode == `CSR_ECODE_ALE) begin
                    m_badv <= wb_vaddr;
                end
            end else if (ertn_flush) begin
                m_crmd <= {m_crmd[3], m_prmd};
            end
            // timer start, reload or countdown
            if (csr_we && csr_num == `CSR_NUM_TCFG && tcfg_after[0]) begin
                m_count <= {tcfg_after[31:2], 2'b00};
            end else if (m_tcfg[0] && m_count != `CSR_TIMER_IDLE) begin
                if (m_count == '0 && m_tcfg[1]) begin
                    m_count <= {m_tcfg[31:2], 2'b00};
                end else begin
                    m_count <= m_count - 1;
                end
            end
            if (m_count == '0) begin
                m_ti <= 1'b1;
            end else if (csr_we && csr_num == `CSR_NUM_TICLR && csr_wmask[0] && csr_wvalue[0]) begin
                m_ti <= 1'b0;
            end
        end
    end

    assign m_is        = {m_ipi, m_ti, 1'b0, m_hwi, m_swi};
    assign exp_has_int = |(m_is[11:0] & m_ecfg[11:0]) && m_crmd[2];

    always_comb begin
        case (csr_num)
            `CSR_NUM_CRMD:   exp_rvalue = {28'b0, m_crmd};
            `CSR_NUM_PRMD:   exp_rvalue = {29'b0, m_prmd};
            `CSR_NUM_ECFG:   exp_rvalue = {19'b0, m_ecfg};
            `CSR_NUM_ESTAT:  exp_rvalue = {1'b0, m_esub, m_ecode, 3'b0, m_is};
            `CSR_NUM_ERA:    exp_rvalue = m_era;
            `CSR_NUM_BADV:   exp_rvalue = m_badv;
            `CSR_NUM_EENTRY: exp_rvalue = m_eentry;
            `CSR_NUM_SAVE0:  exp_rvalue = m_save[0];
            `CSR_NUM_SAVE1:  exp_rvalue = m_save[1];
            `CSR_NUM_SAVE2:  exp_rvalue = m_save[2];
            `CSR_NUM_SAVE3:  exp_rvalue = m_save[3];
            `CSR_NUM_TCFG:   exp_rvalue = m_tcfg;
            `CSR_NUM_TVAL:   exp_rvalue = m_count;
            default:         exp_rvalue = '0;
        endcase
        if (!csr_re) begin
            exp_rvalue = '0;
        end
    end

    task automatic report_mismatch(input string what, input logic [63:0] exp, act);
        errors++;
        $display("FAILED %s %s expected %h actual %h", test_name, what, exp, act);
    endtask

    rvalue_check: assert property (@(posedge clk) disable iff (reset) csr_rvalue === exp_rvalue)
        else report_mismatch("csr_rvalue", $sampled(exp_rvalue), $sampled(csr_rvalue));
    eentry_check: assert property (@(posedge clk) disable iff (reset) csr_eentry === m_eentry)
        else report_mismatch("csr_eentry", $sampled(m_eentry), $sampled(csr_eentry));
    has_int_check: assert property (@(posedge clk) disable iff (reset) has_int === exp_has_int)
        else report_mismatch("has_int", $sampled(exp_has_int), $sampled(has_int));
    stable_check: assert property (@(posedge clk) disable iff (reset)
                                   stable_counter_value === m_stable)
        else report_mismatch("stable", $sampled(m_stable), $sampled(stable_counter_value));

    task automatic write_csr(input logic [13:0] num, input logic [31:0] mask, value);
        @(negedge clk);
        csr_re     = 1'b1;
        csr_num    = num;
        csr_we     = 1'b1;
        csr_wmask  = mask;
        csr_wvalue = value;
        @(negedge clk);
        csr_we = 1'b0;
    endtask

    task automatic read_csr(input logic [13:0] num);
        @(negedge clk);
        csr_re  = 1'b1;
        csr_num = num;
    endtask

    task automatic raise_exception(input logic [5:0] ecode, input logic [8:0] esub);
        @(negedge clk);
        wb_ex       = 1'b1;
        wb_ecode    = ecode;
        wb_esubcode = esub;
        wb_pc       = $urandom;
        wb_vaddr    = $urandom;
        @(negedge clk);
        wb_ex = 1'b0;
    endtask

    task automatic return_exception();
        @(negedge clk);
        ertn_flush = 1'b1;
        @(negedge clk);
        ertn_flush = 1'b0;
    endtask

    task automatic wait_has_int(input int limit);
        int n = 0;
        while (has_int !== 1'b1 && n < limit) begin
            @(negedge clk);
            n++;
        end
        if (has_int !== 1'b1) begin
            errors++;
            $display("%s: has_int did not rise within %0d cycles", test_name, limit);
        end
    endtask

    initial begin
        logic [13:0] rw_nums [7];
        logic [5:0]  exc_codes [4];
        logic [8:0]  exc_subs [4];
        void'($urandom(3));
        reset       = 1'b1;
        csr_re      = 1'b0;
        csr_num     = '0;
        csr_we      = 1'b0;
        csr_wmask   = '0;
        csr_wvalue  = '0;
        wb_ex       = 1'b0;
        ertn_flush  = 1'b0;
        wb_ecode    = '0;
        wb_esubcode = '0;
        wb_pc       = '0;
        wb_vaddr    = '0;
        hw_int_in   = '0;
        ipi_int_in  = 1'b0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        // counter starts at zero right after reset
        test_name = "stable_counter";
        repeat (10) @(negedge clk);

        test_name = "masked_rw";
        rw_nums = '{`CSR_NUM_SAVE0, `CSR_NUM_SAVE1, `CSR_NUM_SAVE2, `CSR_NUM_SAVE3,
                    `CSR_NUM_ERA, `CSR_NUM_EENTRY, `CSR_NUM_ECFG};
        foreach (rw_nums[i]) begin
            repeat (3) write_csr(rw_nums[i], $urandom, $urandom);
        end
        read_csr(14'h100);
        @(negedge clk);
        csr_re  = 1'b0;
        csr_num = `CSR_NUM_SAVE1;

        // ade with subcode 1 and brk both leave badv alone
        test_name = "exception";
        exc_codes = '{`CSR_ECODE_ADE, `CSR_ECODE_ALE, 6'h0c, `CSR_ECODE_ADE};
        exc_subs  = '{9'h0, 9'h0, 9'h0, 9'h1};
        foreach (exc_codes[i]) begin
            write_csr(`CSR_NUM_CRMD, 32'hf, $urandom);
            raise_exception(exc_codes[i], exc_subs[i]);
            read_csr(`CSR_NUM_CRMD);
            read_csr(`CSR_NUM_PRMD);
            read_csr(`CSR_NUM_ERA);
            read_csr(`CSR_NUM_ESTAT);
            read_csr(`CSR_NUM_BADV);
            return_exception();
            read_csr(`CSR_NUM_CRMD);
        end

        test_name = "interrupts";
        repeat (16) begin
            write_csr(`CSR_NUM_CRMD, 32'h4, $urandom);
            write_csr(`CSR_NUM_ECFG, 32'h1fff, $urandom);
            write_csr(`CSR_NUM_ESTAT, 32'h3, $urandom);
            @(negedge clk);
            hw_int_in  = 8'($urandom);
            ipi_int_in = 1'($urandom);
            read_csr(`CSR_NUM_ESTAT);
        end
        write_csr(`CSR_NUM_ESTAT, 32'h3, 32'h0);
        hw_int_in  = '0;
        ipi_int_in = 1'b0;

        test_name = "timer_oneshot";
        write_csr(`CSR_NUM_ECFG, 32'h1fff, 32'h800);
        write_csr(`CSR_NUM_CRMD, 32'h4, 32'h4);
        write_csr(`CSR_NUM_TCFG, 32'hffff_ffff, {30'd5, 2'b01});
        read_csr(`CSR_NUM_TVAL);
        wait_has_int(40);
        repeat (4) @(negedge clk);
        write_csr(`CSR_NUM_TICLR, 32'h1, 32'h1);
        read_csr(`CSR_NUM_ESTAT);

        test_name = "timer_periodic";
        write_csr(`CSR_NUM_TCFG, 32'hffff_ffff, {30'd3, 2'b11});
        repeat (3) begin
            read_csr(`CSR_NUM_TVAL);
            wait_has_int(30);
            write_csr(`CSR_NUM_TICLR, 32'h1, 32'h1);
        end
        write_csr(`CSR_NUM_TCFG, 32'hffff_ffff, 32'h0);
        write_csr(`CSR_NUM_TICLR, 32'h1, 32'h1);
        read_csr(`CSR_NUM_TVAL);
        repeat (3) @(negedge clk);

        $display("summary: %0d errors in %0d cycles", errors, cycles);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

    // run length limit
    initial begin
        while (cycles < timeout_cycles) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: run did not finish within %0d cycles", timeout_cycles);
        $display("TEST FAIL");
        $finish;
    end

endmodule
